//--- src/ieu_pkg.sv
// Shared widths, opcode and ALU function encodings, and stage structs for the integer unit
package ieu_pkg;

    // ==============================
    // Widths
    // ==============================

    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;
    localparam int ROB_IDX_WIDTH = 5;
    localparam int SHAMT_WIDTH   = 5;

    // ==============================
    // Encodings
    // ==============================

    // Operation classes as presented by the issue port
    typedef enum logic [2:0] {
        OPC_REG    = 3'd0,
        OPC_IMM    = 3'd1,
        OPC_LUI    = 3'd2,
        OPC_AUIPC  = 3'd3,
        OPC_JAL    = 3'd4,
        OPC_JALR   = 3'd5,
        OPC_BRANCH = 3'd6
    } opcode_t;

    // Compare functions return 0 or 1 in bit 0 of the result
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SRL = 4'd6,
        SRA = 4'd7,
        EQ  = 4'd8,
        NE  = 4'd9,
        LT  = 4'd10,
        LTU = 4'd11,
        GE  = 4'd12,
        GEU = 4'd13
    } alu_func_t;

    // ==============================
    // Stage structs
    // ==============================

    typedef struct packed {
        opcode_t                  opcode;
        logic [2:0]               funct3;
        logic                     funct7_5;
        logic [DATA_WIDTH-1:0]    rs1;
        logic [DATA_WIDTH-1:0]    rs2;
        logic [ADDR_WIDTH-1:0]    iaddr;
        logic [DATA_WIDTH-1:0]    imm;
        logic [ROB_IDX_WIDTH-1:0] tag;
        logic                     valid;
    } ieu_issue_t;

    typedef struct packed {
        alu_func_t alu_func;
        logic      jmp;
        logic      br;
        logic      valid;
    } ieu_ctrl_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]    src_a;
        logic [DATA_WIDTH-1:0]    src_b;
        logic [ADDR_WIDTH-1:0]    iaddr;
        logic [DATA_WIDTH-1:0]    imm_b;
        logic [SHAMT_WIDTH-1:0]   shamt;
        logic [ROB_IDX_WIDTH-1:0] tag;
    } ieu_opnd_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]    data;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [ROB_IDX_WIDTH-1:0] tag;
        logic                     redirect;
        logic                     valid;
    } ieu_result_t;

endpackage

//--- src/ieu_ctrl.sv
// Decode-stage control, turns the issued operation class into ALU function and jump/branch flags
`timescale 1ns/1ps

module ieu_ctrl (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_flush,
    input  ieu_pkg::ieu_issue_t    i_issue,

    output ieu_pkg::ieu_ctrl_t     o_ctrl
);

    logic                  sub_en;
    ieu_pkg::alu_func_t    arith_func;
    ieu_pkg::alu_func_t    br_func;
    ieu_pkg::alu_func_t    alu_func;
    logic                  jmp;
    logic                  br;

    ieu_pkg::alu_func_t    func_q;
    logic                  jmp_q;
    logic                  br_q;
    logic                  valid_q;

    // Immediate ops have no subtract, so funct7 bit 5 only picks SRA there
    assign sub_en = i_issue.funct7_5 & (i_issue.opcode == ieu_pkg::OPC_REG);

    // ==============================
    // Function decode
    // ==============================

    always_comb begin
        case (i_issue.funct3)
            3'b000:  arith_func = sub_en ? ieu_pkg::SUB : ieu_pkg::ADD;
            3'b001:  arith_func = ieu_pkg::SLL;
            3'b010:  arith_func = ieu_pkg::LT;
            3'b011:  arith_func = ieu_pkg::LTU;
            3'b100:  arith_func = ieu_pkg::XOR;
            3'b101:  arith_func = i_issue.funct7_5 ? ieu_pkg::SRA : ieu_pkg::SRL;
            3'b110:  arith_func = ieu_pkg::OR;
            default: arith_func = ieu_pkg::AND;
        endcase
    end

    always_comb begin
        case (i_issue.funct3)
            3'b000:  br_func = ieu_pkg::EQ;
            3'b001:  br_func = ieu_pkg::NE;
            3'b100:  br_func = ieu_pkg::LT;
            3'b101:  br_func = ieu_pkg::GE;
            3'b110:  br_func = ieu_pkg::LTU;
            3'b111:  br_func = ieu_pkg::GEU;
            // Unused branch encoding, the ALU returns 0 so it never redirects
            default: br_func = ieu_pkg::alu_func_t'(4'hf);
        endcase
    end

    always_comb begin
        alu_func = ieu_pkg::ADD;
        jmp      = 1'b0;
        br       = 1'b0;
        case (i_issue.opcode)
            ieu_pkg::OPC_REG:    alu_func = arith_func;
            ieu_pkg::OPC_IMM:    alu_func = arith_func;
            ieu_pkg::OPC_JAL:    jmp      = 1'b1;
            ieu_pkg::OPC_JALR:   jmp      = 1'b1;
            ieu_pkg::OPC_BRANCH: begin
                alu_func = br_func;
                br       = 1'b1;
            end
            default:             alu_func = ieu_pkg::ADD;
        endcase
    end

    // ==============================
    // Decode register
    // ==============================

    always_ff @(posedge clk) begin
        if (~n_rst) valid_q <= 1'b0;
        else        valid_q <= i_issue.valid & ~i_flush;
    end

    always_ff @(posedge clk) begin
        func_q <= alu_func;
        jmp_q  <= jmp;
        br_q   <= br;
    end

    assign o_ctrl = '{alu_func: func_q, jmp: jmp_q, br: br_q, valid: valid_q};

endmodule

//--- src/ieu_opsel.sv
// Decode-stage operand select that registers the ALU sources and address fields for execute
`timescale 1ns/1ps

module ieu_opsel (
    input  logic                   clk,

    input  ieu_pkg::ieu_issue_t    i_issue,

    output ieu_pkg::ieu_opnd_t     o_opnd
);

    logic [ieu_pkg::DATA_WIDTH-1:0]  src_a;
    logic [ieu_pkg::DATA_WIDTH-1:0]  src_b;
    logic [ieu_pkg::SHAMT_WIDTH-1:0] shamt;

    // Source A is zero for LUI and the instruction address for PC-relative ops
    always_comb begin
        case (i_issue.opcode)
            ieu_pkg::OPC_LUI:   src_a = '0;
            ieu_pkg::OPC_AUIPC: src_a = i_issue.iaddr;
            ieu_pkg::OPC_JAL:   src_a = i_issue.iaddr;
            default:            src_a = i_issue.rs1;
        endcase
    end

    // Only register ops and branches take rs2 as source B
    always_comb begin
        case (i_issue.opcode)
            ieu_pkg::OPC_REG:    src_b = i_issue.rs2;
            ieu_pkg::OPC_BRANCH: src_b = i_issue.rs2;
            default:             src_b = i_issue.imm;
        endcase
    end

    // Immediate ops already carry the immediate as source B, so it supplies their shift amount
    assign shamt = src_b[ieu_pkg::SHAMT_WIDTH-1:0];

    // Validity travels in the control register and only the payload is held here
    always_ff @(posedge clk) begin
        o_opnd.src_a <= src_a;
        o_opnd.src_b <= src_b;
        o_opnd.iaddr <= i_issue.iaddr;
        o_opnd.imm_b <= i_issue.imm;
        o_opnd.shamt <= shamt;
        o_opnd.tag   <= i_issue.tag;
    end

endmodule

//--- src/ieu_ex.sv
// Execute stage, runs the ALU and resolves jumps and branches into data, target and redirect
`timescale 1ns/1ps

module ieu_ex (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_flush,
    input  ieu_pkg::ieu_ctrl_t     i_ctrl,
    input  ieu_pkg::ieu_opnd_t     i_opnd,

    output ieu_pkg::ieu_result_t   o_result
);

    localparam int DW = ieu_pkg::DATA_WIDTH;

    logic [DW-1:0]                      result;
    logic [2*DW-1:0]                    e_src_a;
    logic signed [DW-1:0]               s_src_a;
    logic signed [DW-1:0]               s_src_b;
    logic                               cmp;

    logic [DW-1:0]                      data_q;
    logic [ieu_pkg::ADDR_WIDTH-1:0]     addr_q;
    logic [ieu_pkg::ROB_IDX_WIDTH-1:0]  tag_q;
    logic                               redirect_q;
    logic                               valid_q;

    // Sign-extended copy of source A, shifting it right gives SRA
    assign e_src_a = {{DW{i_opnd.src_a[DW-1]}}, i_opnd.src_a};
    assign s_src_a = i_opnd.src_a;
    assign s_src_b = i_opnd.src_b;

    // ==============================
    // ALU
    // ==============================

    always_comb begin
        cmp    = 1'b0;
        result = '0;
        case (i_ctrl.alu_func)
            ieu_pkg::ADD: result = i_opnd.src_a + i_opnd.src_b;
            ieu_pkg::SUB: result = i_opnd.src_a - i_opnd.src_b;
            ieu_pkg::AND: result = i_opnd.src_a & i_opnd.src_b;
            ieu_pkg::OR:  result = i_opnd.src_a | i_opnd.src_b;
            ieu_pkg::XOR: result = i_opnd.src_a ^ i_opnd.src_b;
            ieu_pkg::SLL: result = i_opnd.src_a << i_opnd.shamt;
            ieu_pkg::SRL: result = i_opnd.src_a >> i_opnd.shamt;
            ieu_pkg::SRA: result = DW'(e_src_a >> i_opnd.shamt);
            ieu_pkg::EQ:  cmp    = i_opnd.src_a == i_opnd.src_b;
            ieu_pkg::NE:  cmp    = i_opnd.src_a != i_opnd.src_b;
            ieu_pkg::LT:  cmp    = s_src_a < s_src_b;
            ieu_pkg::LTU: cmp    = i_opnd.src_a < i_opnd.src_b;
            ieu_pkg::GE:  cmp    = s_src_a >= s_src_b;
            ieu_pkg::GEU: cmp    = i_opnd.src_a >= i_opnd.src_b;
            default:      result = '0;
        endcase
        if (cmp) result = {{(DW-1){1'b0}}, 1'b1};
    end

    // ==============================
    // Result register
    // ==============================

    always_ff @(posedge clk) begin
        if (~n_rst) valid_q <= 1'b0;
        else        valid_q <= i_ctrl.valid & ~i_flush;
    end

    // Jumps link to the next instruction and redirect to the ALU target
    always_ff @(posedge clk) begin
        data_q     <= i_ctrl.jmp ? i_opnd.iaddr + 32'd4 : result;
        addr_q     <= i_ctrl.jmp ? {result[DW-1:1], 1'b0} : i_opnd.iaddr + i_opnd.imm_b;
        redirect_q <= i_ctrl.jmp | (i_ctrl.br & result[0]);
        tag_q      <= i_opnd.tag;
    end

    assign o_result = '{data: data_q, addr: addr_q, tag: tag_q,
                        redirect: redirect_q, valid: valid_q};

endmodule

//--- src/ieu.sv
// Integer execution unit top level, connects decode control, operand select and execute
`timescale 1ns/1ps

module ieu (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_flush,
    input  ieu_pkg::ieu_issue_t    i_issue,

    output ieu_pkg::ieu_result_t   o_result
);

    // ==============================
    // Decode stage
    // ==============================

    ieu_pkg::ieu_ctrl_t ctrl;
    ieu_pkg::ieu_opnd_t opnd;

    ieu_ctrl u_ctrl (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_flush (i_flush),
        .i_issue (i_issue),
        .o_ctrl  (ctrl)
    );

    ieu_opsel u_opsel (
        .clk     (clk),
        .i_issue (i_issue),
        .o_opnd  (opnd)
    );

    // ==============================
    // Execute stage
    // ==============================

    ieu_ex u_ex (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_ctrl   (ctrl),
        .i_opnd   (opnd),
        .o_result (o_result)
    );

endmodule

//--- verif/ieu_tb_model.svh
// Reference model of the integer unit that the testbench includes to derive expected results
`ifndef IEU_TB_MODEL_SVH
`define IEU_TB_MODEL_SVH

function automatic logic is_jump(input ieu_pkg::ieu_issue_t op);
    return op.opcode inside {ieu_pkg::OPC_JAL, ieu_pkg::OPC_JALR};
endfunction

// Operand selection and ALU function follow the decode table of the operation class
function automatic logic [ieu_pkg::DATA_WIDTH-1:0] alu_result(input ieu_pkg::ieu_issue_t op);
    logic [ieu_pkg::DATA_WIDTH-1:0]  a;
    logic [ieu_pkg::DATA_WIDTH-1:0]  b;
    logic [ieu_pkg::SHAMT_WIDTH-1:0] sh;
    logic [ieu_pkg::DATA_WIDTH-1:0]  r;
    a = op.rs1;
    b = op.imm;
    if (op.opcode inside {ieu_pkg::OPC_REG, ieu_pkg::OPC_BRANCH}) b = op.rs2;
    if (op.opcode == ieu_pkg::OPC_LUI) a = '0;
    if (op.opcode inside {ieu_pkg::OPC_AUIPC, ieu_pkg::OPC_JAL}) a = op.iaddr;
    sh = b[ieu_pkg::SHAMT_WIDTH-1:0];
    r  = a + b;
    if (op.opcode inside {ieu_pkg::OPC_REG, ieu_pkg::OPC_IMM}) begin
        case (op.funct3)
            3'd0: r = (op.opcode == ieu_pkg::OPC_REG && op.funct7_5) ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = ieu_pkg::DATA_WIDTH'($signed(a) < $signed(b));
            3'd3: r = ieu_pkg::DATA_WIDTH'(a < b);
            3'd4: r = a ^ b;
            3'd5: begin
                if (op.funct7_5) r = $signed(a) >>> sh;
                else r = a >> sh;
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
    end else if (op.opcode == ieu_pkg::OPC_BRANCH) begin
        case (op.funct3)
            3'd0: r = ieu_pkg::DATA_WIDTH'(a == b);
            3'd1: r = ieu_pkg::DATA_WIDTH'(a != b);
            3'd4: r = ieu_pkg::DATA_WIDTH'($signed(a) < $signed(b));
            3'd5: r = ieu_pkg::DATA_WIDTH'($signed(a) >= $signed(b));
            3'd6: r = ieu_pkg::DATA_WIDTH'(a < b);
            3'd7: r = ieu_pkg::DATA_WIDTH'(a >= b);
            default: r = '0;
        endcase
    end
    return r;
endfunction

function automatic logic [ieu_pkg::DATA_WIDTH-1:0] result_data(input ieu_pkg::ieu_issue_t op);
    return is_jump(op) ? op.iaddr + 32'd4 : alu_result(op);
endfunction

function automatic logic [ieu_pkg::ADDR_WIDTH-1:0] target_addr(input ieu_pkg::ieu_issue_t op);
    return is_jump(op) ? alu_result(op) & ~32'd1 : op.iaddr + op.imm;
endfunction

function automatic logic redirect_flag(input ieu_pkg::ieu_issue_t op);
    logic [ieu_pkg::DATA_WIDTH-1:0] r;
    r = alu_result(op);
    return is_jump(op) | ((op.opcode == ieu_pkg::OPC_BRANCH) & r[0]);
endfunction

`endif

//--- verif/ieu_tb.sv
// Self-checking testbench for the integer unit that applies a stimulus table and checks each result
`timescale 1ns/1ps

module ieu_tb;

    typedef struct packed {
        ieu_pkg::ieu_issue_t            issue;
        logic                           flush;
        logic [ieu_pkg::DATA_WIDTH-1:0] exp_data;
        logic [ieu_pkg::ADDR_WIDTH-1:0] exp_addr;
        logic                           exp_redirect;
    } row_t;

    logic                  clk;
    logic                  n_rst;
    logic                  i_flush;
    ieu_pkg::ieu_issue_t   i_issue;
    ieu_pkg::ieu_result_t  o_result;

    row_t                  rows[$];
    ieu_pkg::ieu_result_t  expq[$];
    integer                seed = 83350;
    int                    cycle_cnt = 0;
    int                    cycle_limit = 1000;

    `include "ieu_tb_model.svh"

    ieu i_dut (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_issue  (i_issue),
        .o_result (o_result)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout, the stimulus table did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // ==============================
    // Table construction
    // ==============================

    function automatic logic [31:0] sext12(input logic [31:0] v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    task automatic add_row(input ieu_pkg::opcode_t opc, input logic [2:0] f3, input logic f7,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] imm, input logic flush);
        row_t r;
        r.issue.opcode   = opc;
        r.issue.funct3   = f3;
        r.issue.funct7_5 = f7;
        r.issue.rs1      = rs1;
        r.issue.rs2      = rs2;
        r.issue.iaddr    = $random(seed) & 32'hffff_fffc;
        r.issue.imm      = imm;
        r.issue.tag      = ieu_pkg::ROB_IDX_WIDTH'(rows.size());
        r.issue.valid    = 1'b1;
        r.flush          = flush;
        r.exp_data       = result_data(r.issue);
        r.exp_addr       = target_addr(r.issue);
        r.exp_redirect   = redirect_flag(r.issue);
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] corner [4] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        int          shift_amt [4] = '{0, 31, 1, 16};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int f7 = 0; f7 < 2; f7++) begin
                a = $random(seed);
                b = $random(seed);
                c = sext12($random(seed));
                add_row(ieu_pkg::OPC_REG, 3'(f3), 1'(f7), a, b, c, 1'b0);
                add_row(ieu_pkg::OPC_IMM, 3'(f3), 1'(f7), a, b, c, 1'b0);
            end
            // Corner operand pairs with funct7 alternating so SUB and SRA are reached
            for (int i = 0; i < 16; i++) begin
                a = corner[i / 4];
                b = corner[i % 4];
                add_row(ieu_pkg::OPC_REG, 3'(f3), 1'(i + f3), a, b, sext12(b), 1'b0);
                add_row(ieu_pkg::OPC_IMM, 3'(f3), 1'(i + f3), a, b, sext12(b), 1'b0);
                add_row(ieu_pkg::OPC_BRANCH, 3'(f3), 1'b0, a, b, 32'h10, 1'b0);
            end
            for (int k = 0; k < 3; k++) begin
                a = $random(seed);
                b = (k == 0) ? a : ((k == 1) ? ~a : $random(seed));
                c = sext12($random(seed)) & 32'hffff_fffe;
                add_row(ieu_pkg::OPC_BRANCH, 3'(f3), 1'b0, a, b, c, 1'b0);
            end
        end
        // Shifts of a negative value where rs2 and the immediate hold different amounts
        for (int s = 0; s < 8; s++) begin
            a = 32'h8000_00f1 ^ ($random(seed) & 32'h0fff_0000);
            b = ($random(seed) & 32'hffff_ffe0) | shift_amt[3 - s / 2];
            c = ((s % 2) ? 32'h400 : 32'h0) | shift_amt[s / 2];
            add_row(ieu_pkg::OPC_REG, 3'd1, 1'(s), a, b, c, 1'b0);
            add_row(ieu_pkg::OPC_REG, 3'd5, 1'(s), a, b, c, 1'b0);
            add_row(ieu_pkg::OPC_IMM, 3'd1, 1'(s), a, b, c, 1'b0);
            add_row(ieu_pkg::OPC_IMM, 3'd5, 1'(s), a, b, c, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            a = $random(seed);
            b = $random(seed);
            c = $random(seed) & 32'hffff_f000;
            add_row(ieu_pkg::OPC_LUI, 3'd0, 1'b0, a, b, c, 1'b0);
            add_row(ieu_pkg::OPC_AUIPC, 3'd0, 1'b0, a, b, c, 1'b0);
            add_row(ieu_pkg::OPC_JAL, 3'd0, 1'b0, a, b, sext12(c >> 12) & ~32'd1, 1'b0);
            add_row(ieu_pkg::OPC_JALR, 3'd0, 1'b0, a, b, sext12($random(seed)), 1'b0);
        end
        // Back-to-back adds with flush in selected cycles
        for (int k = 0; k < 12; k++) begin
            a = $random(seed);
            b = $random(seed);
            add_row(ieu_pkg::OPC_REG, 3'd0, 1'b0, a, b, 32'h0, 1'(k inside {3, 6, 7, 11}));
        end
    endtask

    // ==============================
    // Driver and checker
    // ==============================

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_result(input ieu_pkg::ieu_result_t exp);
        if (exp.valid) begin
            assert (o_result.valid === 1'b1) else begin
                $display("The result for tag %0d did not arrive in its cycle", exp.tag);
                abort_run();
            end
            check_field("o_result.data", exp.data, o_result.data);
            check_field("o_result.addr", exp.addr, o_result.addr);
            check_field("o_result.tag", 32'(exp.tag), 32'(o_result.tag));
            check_field("o_result.redirect", 32'(exp.redirect), 32'(o_result.redirect));
        end else begin
            assert (o_result.valid === 1'b0) else begin
                $display("A valid result appeared where none was expected, tag %0d", o_result.tag);
                abort_run();
            end
        end
    endtask

    function automatic ieu_pkg::ieu_result_t expected_result(input row_t r);
        ieu_pkg::ieu_result_t e;
        e.data     = r.exp_data;
        e.addr     = r.exp_addr;
        e.tag      = r.issue.tag;
        e.redirect = r.exp_redirect;
        e.valid    = 1'b1;
        return e;
    endfunction

    // Check the slot due this cycle, then drive the next issue on the falling edge
    task automatic apply_cycle(input ieu_pkg::ieu_issue_t issue, input logic flush,
                               input logic rst_val, input ieu_pkg::ieu_result_t exp);
        ieu_pkg::ieu_result_t due;
        ieu_pkg::ieu_result_t slot;
        @(negedge clk);
        due = expq.pop_front();
        compare_result(due);
        n_rst   = rst_val;
        i_flush = flush;
        i_issue = issue;
        slot    = exp;
        // Flush kills this issue and the operation now in decode
        if (flush) begin
            slot.valid = 1'b0;
            expq[expq.size()-1].valid = 1'b0;
        end
        expq.push_back(slot);
    endtask

    initial begin
        n_rst   = 1'b0;
        i_flush = 1'b0;
        i_issue = '0;
        build_table();
        cycle_limit = rows.size() + 20;
        expq.push_back('0);
        expq.push_back('0);
        i_issue = rows[0].issue;
        // The first rising edge samples reset with a valid issue on the port
        @(posedge clk);
        apply_cycle(rows[1].issue, 1'b0, 1'b0, '0);
        foreach (rows[k]) begin
            apply_cycle(rows[k].issue, rows[k].flush, 1'b1, expected_result(rows[k]));
        end
        repeat (2) apply_cycle('0, 1'b0, 1'b1, '0);
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- compile.f
+incdir+verif
src/ieu_pkg.sv
src/ieu_ctrl.sv
src/ieu_opsel.sv
src/ieu_ex.sv
src/ieu.sv
verif/ieu_tb.sv

//--- Bender.yml
package:
  name: ieu

sources:
  - src/ieu_pkg.sv
  - src/ieu_ctrl.sv
  - src/ieu_opsel.sv
  - src/ieu_ex.sv
  - src/ieu.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/ieu_tb.sv
